/* include/riscv_consts.svh */
// Core-wide constants
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// ==============================
// Datapath widths
// ==============================

`define XLEN        32   // Data and address width
`define REG_ADDR_W  5    // Register index width
`define NUM_REGS    32   // Architectural registers, x0 included

// Both memory ports carry word addresses
`define WORD_ADDR_W 30

// ==============================
// Fixed encodings
// ==============================

// addi x0, x0, 0
`define NOP_INST    32'h0000_0013

// First fetch address after reset
`define RESET_PC    32'h0000_0000

`endif

/* rtl/riscvPkg.sv */
// Pipeline types and helpers
`include "riscv_consts.svh"

package riscvPkg;

	// Base opcodes of the supported subset
	typedef enum logic [6:0] {
		OP_REG    = 7'b0110011,
		OP_IMM    = 7'b0010011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111
	} opcode_t;

	// Encoded as {funct7[5], funct3}
	typedef enum logic [3:0] {
		ALU_ADD = 4'b0000,
		ALU_SLL = 4'b0001,
		ALU_SLT = 4'b0010,
		ALU_XOR = 4'b0100,
		ALU_SRL = 4'b0101,
		ALU_OR  = 4'b0110,
		ALU_AND = 4'b0111,
		ALU_SUB = 4'b1000,
		ALU_SRA = 4'b1101
	} aluOp_t;

	// ==============================
	// Stage payloads
	// ==============================

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] pcPlus4;
		logic [`XLEN-1:0] inst;
	} ifId_t;

	typedef struct packed {
		logic [`XLEN-1:0]       rs1Data;
		logic [`XLEN-1:0]       rs2Data;
		logic [`XLEN-1:0]       imm;
		logic [`XLEN-1:0]       pcPlus4;
		logic [`REG_ADDR_W-1:0] rs1Addr;
		logic [`REG_ADDR_W-1:0] rs2Addr;
		logic [`REG_ADDR_W-1:0] rdAddr;
		aluOp_t                 aluOp;
		logic                   aluSrc;   // Second operand is the immediate
		logic                   memRead;
		logic                   memWrite;
		logic                   memToReg;
		logic                   regWrite;
		logic                   isJump;
	} idEx_t;

	typedef struct packed {
		logic [`XLEN-1:0]       aluResult;
		logic [`XLEN-1:0]       storeData;  // Little-endian memory order
		logic [`REG_ADDR_W-1:0] rdAddr;
		logic [`XLEN-1:0]       pcPlus4;
		logic                   memRead;
		logic                   memWrite;
		logic                   memToReg;
		logic                   regWrite;
		logic                   isJump;
	} exMem_t;

	typedef struct packed {
		logic [`XLEN-1:0]       aluResult;
		logic [`XLEN-1:0]       loadData;   // Back in core order
		logic [`REG_ADDR_W-1:0] rdAddr;
		logic [`XLEN-1:0]       pcPlus4;
		logic                   memToReg;
		logic                   regWrite;
		logic                   isJump;
	} memWb_t;

	// Memory is little-endian, the core works on swapped words
	function automatic logic [`XLEN-1:0] byteSwap(input logic [`XLEN-1:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Newest producer wins, MEM before WB, x0 never forwarded
	function automatic logic [`XLEN-1:0] fwdValue(
		input logic [`REG_ADDR_W-1:0] src,
		input logic [`XLEN-1:0]       regVal,
		input exMem_t                 mem,
		input logic [`REG_ADDR_W-1:0] wbAddr,
		input logic [`XLEN-1:0]       wbData,
		input logic                   wbWrite
	);
		if (src == '0) begin
			return regVal;
		end else if (mem.regWrite && mem.rdAddr == src) begin
			return mem.aluResult;
		end else if (wbWrite && wbAddr == src) begin
			return wbData;
		end
		return regVal;
	endfunction

endpackage

/* rtl/stageReg.sv */
// Pipeline stage register
`timescale 1ns/1ps

module stageReg #(
	parameter type      payload_t = logic,
	parameter payload_t bubble    = '0
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     hold,   // Keep current contents
	input  logic     flush,  // Load a bubble
	input  payload_t d,
	output payload_t q
);

	// Hold wins over flush so a stalled stage keeps its instruction
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			q <= bubble;
		end else if (hold) begin
			q <= q;
		end else if (flush) begin
			q <= bubble;
		end else begin
			q <= d;
		end
	end

endmodule

/* rtl/fetchUnit.sv */
// Fetch and ID-stage branch resolution
`timescale 1ns/1ps
`include "riscv_consts.svh"

module fetchUnit import riscvPkg::*; (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    freeze,    // Any stall, PC holds
	input  logic [`XLEN-1:0]        iRdata,
	input  ifId_t                   id,
	input  logic [`XLEN-1:0]        imm,
	input  logic [`XLEN-1:0]        rs1Data,
	input  logic [`XLEN-1:0]        rs2Data,
	input  logic                    jal,
	input  logic                    jalr,
	input  logic                    beq,
	input  logic                    bne,
	input  exMem_t                  exMem,
	input  logic [`REG_ADDR_W-1:0]  wbAddr,
	input  logic [`XLEN-1:0]        wbData,
	input  logic                    wbWrite,
	output ifId_t                   ifOut,
	output logic [`WORD_ADDR_W-1:0] iAddr,
	output logic                    iRead,
	output logic                    branchTaken,
	output logic                    regEq
);

	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] pcPlus4;
	logic [`XLEN-1:0] nextPc;
	logic [`XLEN-1:0] cmpRs1;
	logic [`XLEN-1:0] cmpRs2;

	// Compare operands see results not yet written back
	assign cmpRs1 = fwdValue(id.inst[19:15], rs1Data, exMem, wbAddr, wbData, wbWrite);
	assign cmpRs2 = fwdValue(id.inst[24:20], rs2Data, exMem, wbAddr, wbData, wbWrite);

	assign regEq = (cmpRs1 == cmpRs2);
	assign branchTaken = jal | jalr | (beq & regEq) | (bne & ~regEq);
	assign pcPlus4 = pc + `XLEN'd4;

	always_comb begin
		nextPc = pcPlus4;
		if (freeze) begin
			nextPc = pc;
		end else if (jalr) begin
			nextPc = cmpRs1 + imm;
			nextPc[0] = 1'b0;  // Target LSB is cleared
		end else if (branchTaken) begin
			nextPc = id.pc + imm;  // jal or taken branch
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `RESET_PC;
		end else begin
			pc <= nextPc;
		end
	end

	assign iAddr = pc[`XLEN-1:2];
	assign iRead = rst_n;
	assign ifOut = '{pc: pc, pcPlus4: pcPlus4, inst: byteSwap(iRdata)};

endmodule

/* rtl/decodeUnit.sv */
// Instruction decode
`timescale 1ns/1ps
`include "riscv_consts.svh"

module decodeUnit import riscvPkg::*; (
	input  logic [`XLEN-1:0] inst,
	input  logic [`XLEN-1:0] pc,
	input  logic [`XLEN-1:0] pcPlus4,
	input  logic [`XLEN-1:0] rs1Data,
	input  logic [`XLEN-1:0] rs2Data,
	output idEx_t            decoded,
	output logic             jal,
	output logic             jalr,
	output logic             beq,
	output logic             bne
);

	opcode_t          opcode;
	logic [2:0]       funct3;
	logic [`XLEN-1:0] immI;
	logic [`XLEN-1:0] immS;
	logic [`XLEN-1:0] immB;
	logic [`XLEN-1:0] immJ;

	assign opcode = opcode_t'(inst[6:0]);
	assign funct3 = inst[14:12];

	// ==============================
	// Immediate formats
	// ==============================
	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		decoded = '0;   // Unknown opcodes leave every control off
		jal = 1'b0;
		jalr = 1'b0;
		beq = 1'b0;
		bne = 1'b0;
		decoded.rs1Data = rs1Data;
		decoded.rs2Data = rs2Data;
		decoded.pcPlus4 = pcPlus4;
		decoded.rs1Addr = inst[19:15];
		decoded.rs2Addr = inst[24:20];
		decoded.rdAddr = inst[11:7];
		decoded.aluOp = ALU_ADD;
		case (opcode)
			OP_REG: begin
				decoded.aluOp = aluOp_t'({inst[30], funct3});
				decoded.regWrite = 1'b1;
			end
			OP_IMM: begin
				decoded.imm = immI;
				decoded.aluSrc = 1'b1;
				decoded.regWrite = 1'b1;
				// Bit 30 only selects srai
				decoded.aluOp = aluOp_t'({(funct3 == 3'b101) & inst[30], funct3});
			end
			OP_LOAD: begin
				decoded.imm = immI;
				decoded.aluSrc = 1'b1;
				decoded.memRead = (funct3 == 3'b010);
				decoded.memToReg = (funct3 == 3'b010);
				decoded.regWrite = (funct3 == 3'b010);
			end
			OP_STORE: begin
				decoded.imm = immS;
				decoded.aluSrc = 1'b1;
				decoded.memWrite = (funct3 == 3'b010);
			end
			OP_BRANCH: begin
				decoded.imm = immB;  // Resolved in ID, nothing left for EX
				beq = (funct3 == 3'b000);
				bne = (funct3 == 3'b001);
			end
			OP_JAL, OP_JALR: begin
				decoded.imm = (opcode == OP_JAL) ? immJ : immI;
				jal = (opcode == OP_JAL);
				jalr = (opcode == OP_JALR) && (funct3 == 3'b000);
				// Link address pc + 4 comes out of the ALU for exact MEM forwarding
				decoded.rs1Data = pc;
				decoded.rs2Data = `XLEN'd4;
				decoded.rs1Addr = '0;
				decoded.rs2Addr = '0;
				decoded.regWrite = jal | jalr;
				decoded.isJump = jal | jalr;
			end
			default: begin
				decoded.rdAddr = '0;
			end
		endcase
	end

endmodule

/* rtl/regFile.sv */
// Register file with write-back select
`timescale 1ns/1ps
`include "riscv_consts.svh"

module regFile import riscvPkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`REG_ADDR_W-1:0] rs1Addr,
	input  logic [`REG_ADDR_W-1:0] rs2Addr,
	input  memWb_t                 wb,
	output logic [`XLEN-1:0]       rs1Data,
	output logic [`XLEN-1:0]       rs2Data,
	output logic [`XLEN-1:0]       wbData,
	output logic [`REG_ADDR_W-1:0] wbAddr,
	output logic                   wbWrite
);

	logic [`XLEN-1:0] regs [`NUM_REGS];

	assign wbAddr = wb.rdAddr;
	assign wbWrite = wb.regWrite;
	assign wbData = wb.isJump ? wb.pcPlus4 :
		wb.memToReg ? wb.loadData : wb.aluResult;

	// Write-through so ID sees this cycle's write-back
	assign rs1Data = (wbWrite && wbAddr != '0 && wbAddr == rs1Addr) ? wbData : regs[rs1Addr];
	assign rs2Data = (wbWrite && wbAddr != '0 && wbAddr == rs2Addr) ? wbData : regs[rs2Addr];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wbWrite && wbAddr != '0) begin  // x0 stays zero
			regs[wbAddr] <= wbData;
		end
	end

endmodule

/* rtl/hazardUnit.sv */
// ID-stage hazard detection
`timescale 1ns/1ps
`include "riscv_consts.svh"

module hazardUnit (
	input  logic [`REG_ADDR_W-1:0] rs1Addr,
	input  logic [`REG_ADDR_W-1:0] rs2Addr,
	input  logic                   jalr,
	input  logic                   beq,
	input  logic                   bne,
	input  logic [`REG_ADDR_W-1:0] exRdAddr,
	input  logic                   exMemRead,
	input  logic                   exRegWrite,
	input  logic [`REG_ADDR_W-1:0] memRdAddr,
	input  logic                   memMemRead,
	output logic                   hazardStall,
	output logic                   idExFlush
);

	logic exRs1Hit;
	logic exRs2Hit;
	logic memRs1Hit;
	logic memRs2Hit;
	logic isBranch;
	logic loadUse;
	logic jalrHazard;
	logic branchHazard;
	logic memLoadHazard;

	assign exRs1Hit = (exRdAddr != '0) && (exRdAddr == rs1Addr);
	assign exRs2Hit = (exRdAddr != '0) && (exRdAddr == rs2Addr);
	assign memRs1Hit = memMemRead && (memRdAddr != '0) && (memRdAddr == rs1Addr);
	assign memRs2Hit = memMemRead && (memRdAddr != '0) && (memRdAddr == rs2Addr);
	assign isBranch = beq | bne;

	assign loadUse = exMemRead && (exRs1Hit || exRs2Hit);
	assign jalrHazard = jalr && exRegWrite && exRs1Hit;
	assign branchHazard = isBranch && exRegWrite && (exRs1Hit || exRs2Hit);
	// Load data reaches the ID compare only once the load is in WB
	assign memLoadHazard = (jalr && memRs1Hit) || (isBranch && (memRs1Hit || memRs2Hit));

	assign hazardStall = loadUse | jalrHazard | branchHazard | memLoadHazard;
	assign idExFlush = hazardStall;  // Bubble into EX while ID waits

endmodule

/* rtl/executeUnit.sv */
// Execute stage
`timescale 1ns/1ps
`include "riscv_consts.svh"

module executeUnit import riscvPkg::*; (
	input  idEx_t                  ex,
	input  exMem_t                 exMem,
	input  logic [`XLEN-1:0]       wbData,
	input  logic [`REG_ADDR_W-1:0] wbAddr,
	input  logic                   wbWrite,
	output exMem_t                 exOut
);

	logic [`XLEN-1:0] opA;
	logic [`XLEN-1:0] rs2Fwd;   // Also the store data
	logic [`XLEN-1:0] opB;
	logic [`XLEN-1:0] aluOut;
	logic [4:0]       shamt;

	assign opA = fwdValue(ex.rs1Addr, ex.rs1Data, exMem, wbAddr, wbData, wbWrite);
	assign rs2Fwd = fwdValue(ex.rs2Addr, ex.rs2Data, exMem, wbAddr, wbData, wbWrite);
	assign opB = ex.aluSrc ? ex.imm : rs2Fwd;
	assign shamt = opB[4:0];

	// ==============================
	// ALU
	// ==============================
	always_comb begin
		case (ex.aluOp)
			ALU_ADD: aluOut = opA + opB;
			ALU_SUB: aluOut = opA - opB;
			ALU_SLL: aluOut = opA << shamt;
			ALU_SLT: aluOut = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
			ALU_XOR: aluOut = opA ^ opB;
			ALU_SRL: aluOut = opA >> shamt;
			ALU_SRA: aluOut = $signed(opA) >>> shamt;
			ALU_OR:  aluOut = opA | opB;
			ALU_AND: aluOut = opA & opB;
			default: aluOut = '0;  // Encodings outside the subset
		endcase
	end

	assign exOut = '{
		aluResult: aluOut,
		storeData: byteSwap(rs2Fwd),
		rdAddr:    ex.rdAddr,
		pcPlus4:   ex.pcPlus4,
		memRead:   ex.memRead,
		memWrite:  ex.memWrite,
		memToReg:  ex.memToReg,
		regWrite:  ex.regWrite,
		isJump:    ex.isJump
	};

endmodule

/* rtl/riscvCore.sv */
// Five-stage RV32I pipeline
`timescale 1ns/1ps
`include "riscv_consts.svh"

module riscvCore import riscvPkg::*; (
	input  logic                    clk,
	input  logic                    rst_n,
	// Fetch port
	output logic                    iRead,
	output logic [`WORD_ADDR_W-1:0] iAddr,
	input  logic [`XLEN-1:0]        iRdata,
	input  logic                    iStall,
	// Data port
	output logic                    dRead,
	output logic                    dWrite,
	output logic [`WORD_ADDR_W-1:0] dAddr,
	output logic [`XLEN-1:0]        dWdata,
	input  logic [`XLEN-1:0]        dRdata,
	input  logic                    dStall
);

	localparam ifId_t ifIdBubble = '{pc: '0, pcPlus4: '0, inst: `NOP_INST};

	logic freeze;        // Either port stalled
	logic ifHold;        // PC and IF/ID also wait on hazards
	logic hazardStall;
	logic idExFlush;
	logic branchTaken;
	logic jal;
	logic jalr;
	logic beq;
	logic bne;

	ifId_t  ifStage;
	ifId_t  idStage;
	idEx_t  idDecoded;
	idEx_t  exStage;
	exMem_t exResult;
	exMem_t memStage;
	memWb_t memResult;
	memWb_t wbStage;

	logic [`XLEN-1:0]       rs1Data;
	logic [`XLEN-1:0]       rs2Data;
	logic [`XLEN-1:0]       wbData;
	logic [`REG_ADDR_W-1:0] wbAddr;
	logic                   wbWrite;

	assign freeze = iStall | dStall;
	assign ifHold = freeze | hazardStall;

	// ==============================
	// Data port
	// ==============================
	assign dRead = memStage.memRead;
	assign dWrite = memStage.memWrite;
	assign dAddr = memStage.aluResult[`XLEN-1:2];
	assign dWdata = memStage.storeData;

	assign memResult = '{
		aluResult: memStage.aluResult,
		loadData:  byteSwap(dRdata),
		rdAddr:    memStage.rdAddr,
		pcPlus4:   memStage.pcPlus4,
		memToReg:  memStage.memToReg,
		regWrite:  memStage.regWrite,
		isJump:    memStage.isJump
	};

	// ==============================
	// IF and ID
	// ==============================
	fetchUnit fetch (
		.clk(clk), .rst_n(rst_n), .freeze(ifHold), .iRdata(iRdata), .id(idStage),
		.imm(idDecoded.imm), .rs1Data(rs1Data), .rs2Data(rs2Data),
		.jal(jal), .jalr(jalr), .beq(beq), .bne(bne),
		.exMem(memStage), .wbAddr(wbAddr), .wbData(wbData), .wbWrite(wbWrite),
		.ifOut(ifStage), .iAddr(iAddr), .iRead(iRead),
		.branchTaken(branchTaken), .regEq()
	);

	stageReg #(.payload_t(ifId_t), .bubble(ifIdBubble)) ifIdReg (
		.clk(clk), .rst_n(rst_n), .hold(ifHold), .flush(branchTaken),
		.d(ifStage), .q(idStage)
	);

	decodeUnit decode (
		.inst(idStage.inst), .pc(idStage.pc), .pcPlus4(idStage.pcPlus4),
		.rs1Data(rs1Data), .rs2Data(rs2Data), .decoded(idDecoded),
		.jal(jal), .jalr(jalr), .beq(beq), .bne(bne)
	);

	regFile regs (
		.clk(clk), .rst_n(rst_n),
		.rs1Addr(idStage.inst[19:15]), .rs2Addr(idStage.inst[24:20]), .wb(wbStage),
		.rs1Data(rs1Data), .rs2Data(rs2Data),
		.wbData(wbData), .wbAddr(wbAddr), .wbWrite(wbWrite)
	);

	hazardUnit hazard (
		.rs1Addr(idStage.inst[19:15]), .rs2Addr(idStage.inst[24:20]),
		.jalr(jalr), .beq(beq), .bne(bne),
		.exRdAddr(exStage.rdAddr), .exMemRead(exStage.memRead),
		.exRegWrite(exStage.regWrite),
		.memRdAddr(memStage.rdAddr), .memMemRead(memStage.memRead),
		.hazardStall(hazardStall), .idExFlush(idExFlush)
	);

	// ==============================
	// EX, MEM and WB
	// ==============================
	stageReg #(.payload_t(idEx_t)) idExReg (
		.clk(clk), .rst_n(rst_n), .hold(freeze), .flush(idExFlush),
		.d(idDecoded), .q(exStage)
	);

	executeUnit execute (
		.ex(exStage), .exMem(memStage),
		.wbData(wbData), .wbAddr(wbAddr), .wbWrite(wbWrite),
		.exOut(exResult)
	);

	stageReg #(.payload_t(exMem_t)) exMemReg (
		.clk(clk), .rst_n(rst_n), .hold(freeze), .flush(1'b0),
		.d(exResult), .q(memStage)
	);

	stageReg #(.payload_t(memWb_t)) memWbReg (
		.clk(clk), .rst_n(rst_n), .hold(freeze), .flush(1'b0),
		.d(memResult), .q(wbStage)
	);

endmodule

/* tests/riscvCore_assertions.sv */
// Core port protocol checks
`timescale 1ns/1ps
`include "riscv_consts.svh"

module riscvCore_assertions (
	input logic                    clk,
	input logic                    rst_n,
	input logic [`WORD_ADDR_W-1:0] iAddr,
	input logic                    iStall,
	input logic                    dRead,
	input logic                    dWrite,
	input logic [`WORD_ADDR_W-1:0] dAddr,
	input logic [`XLEN-1:0]        dWdata,
	input logic                    dStall
);

	int failCount = 0;  // Assertion failures so far

	// One data access per cycle
	readWriteExclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(dRead && dWrite))
		else begin
			failCount++;
			$error("dRead and dWrite are high in the same cycle");
		end

	// A stalled store keeps its request steady
	dataPortHold: assert property (@(posedge clk) disable iff (!rst_n)
		dStall |=> ($stable(dAddr) && $stable(dWdata) && $stable(dWrite)))
		else begin
			failCount++;
			$error("Data port request changed while dStall was high");
		end

	fetchHold: assert property (@(posedge clk) disable iff (!rst_n)
		(iStall || dStall) |=> $stable(iAddr))
		else begin
			failCount++;
			$error("iAddr changed while a port stall was high");
		end

	// The reset edge clears the MEM stage
	resetQuiet: assert property (@(posedge clk) !rst_n |=> (!dRead && !dWrite))
		else begin
			failCount++;
			$error("dRead or dWrite high during reset");
		end

endmodule

/* tests/riscvCore_tb.sv */
// Core testbench with ISA model
`timescale 1ns/1ps
`include "riscv_consts.svh"

module riscvCore_tb;

	localparam int MEM_WORDS = 512;
	localparam int BODY_LEN = 60;
	localparam int PROG_LEN = BODY_LEN + 16;  // Body, 15 dump stores, end loop
	localparam int DATA_BASE = 'h400;          // 64-word data area
	localparam int DUMP_BASE = 'h500;
	localparam int RUN_LIMIT = 4000;           // Cycles per program
	localparam int DRAIN_CYCLES = 40;
	localparam int MODEL_LIMIT = 1000;
	localparam int NUM_PROGRAMS = 8;

	logic                    clk;
	logic                    rst_n;
	logic                    iRead;
	logic [`WORD_ADDR_W-1:0] iAddr;
	logic [`XLEN-1:0]        iRdata;
	logic                    iStall;
	logic                    dRead;
	logic                    dWrite;
	logic [`WORD_ADDR_W-1:0] dAddr;
	logic [`XLEN-1:0]        dWdata;
	logic [`XLEN-1:0]        dRdata;
	logic                    dStall;

	logic [31:0] prog [PROG_LEN];
	logic [31:0] imem [MEM_WORDS];      // Bus order, lowest byte address in bits 31:24
	logic [31:0] dmem [MEM_WORDS];
	logic [7:0]  modelMem [MEM_WORDS * 4];
	logic [31:0] modelRegs [32];
	logic [29:0] expAddr [$];
	logic [31:0] expData [$];

	int          storeIdx;
	int          errorCount;
	int          checkCount;
	int          iStallLeft;
	int          dStallLeft;
	bit          stallsOn;
	logic [31:0] rngState;
	string       testName;

	riscvCore riscvCore_i (
		.clk(clk), .rst_n(rst_n),
		.iRead(iRead), .iAddr(iAddr), .iRdata(iRdata), .iStall(iStall),
		.dRead(dRead), .dWrite(dWrite), .dAddr(dAddr), .dWdata(dWdata),
		.dRdata(dRdata), .dStall(dStall)
	);

	bind riscvCore riscvCore_assertions protocolChecks (
		.clk(clk), .rst_n(rst_n), .iAddr(iAddr), .iStall(iStall),
		.dRead(dRead), .dWrite(dWrite), .dAddr(dAddr), .dWdata(dWdata), .dStall(dStall)
	);

	// Memories answer combinationally
	assign iRdata = imem[iAddr[8:0]];
	assign dRdata = dRead ? dmem[dAddr[8:0]] : '0;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ==============================
	// Random numbers and encoders
	// ==============================

	function automatic logic [31:0] nextRand();
		logic [31:0] x;
		x = rngState;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rngState = x;
		return x;
	endfunction

	function automatic logic [4:0] pickReg();
		return 5'(1 + nextRand() % 15);  // x1 to x15
	endfunction

	// Half the time reuse the last destination
	function automatic logic [4:0] pickSrc(input logic [4:0] recent);
		logic [31:0] r;
		r = nextRand();
		return r[0] ? recent : 5'(1 + r[8:1] % 15);
	endfunction

	function automatic logic [2:0] pickFunct3();
		logic [2:0] f3;
		f3 = 3'(nextRand() % 7);
		return (f3 >= 3'd3) ? f3 + 3'd1 : f3;  // No sltu
	endfunction

	function automatic logic [7:0] fillByte(input int unsigned a);
		logic [31:0] h;
		h = a * 32'h9E37_79B1;
		return h[31:24] ^ h[7:0];
	endfunction

	function automatic logic [31:0] regOp(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] immOp(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] storeOp(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] branchOp(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jumpOp(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	task automatic genProgram();
		logic [31:0] r;
		logic [4:0]  rd;
		logic [4:0]  src1;
		logic [4:0]  src2;
		logic [4:0]  lastRd;
		logic [2:0]  f3;
		logic [11:0] imm;
		int          kind;
		int          target;
		lastRd = 5'd1;
		for (int i = 0; i < BODY_LEN; i++) begin
			r = nextRand();
			rd = pickReg();
			src1 = pickSrc(lastRd);
			src2 = pickReg();
			imm = 12'(nextRand());
			f3 = pickFunct3();
			target = i + 1 + int'(r[2:0]);  // Forward only
			if (target > BODY_LEN) begin
				target = BODY_LEN;
			end
			kind = (i < 15) ? 16 : int'(r[7:4]);
			case (kind)
				0, 1, 2, 3, 4, 5: begin
					prog[i] = regOp(((f3 == 3'd0 || f3 == 3'd5) && r[8]) ? 7'h20 : 7'h00,
						src2, src1, f3, rd);
				end
				6, 7, 8: begin
					if (f3 == 3'd1) begin
						imm = {7'h00, imm[4:0]};
					end else if (f3 == 3'd5) begin
						imm = {1'b0, r[8], 5'h00, imm[4:0]};  // srli or srai
					end
					prog[i] = immOp(imm, src1, f3, rd, 7'b0010011);
				end
				9, 10: begin
					prog[i] = immOp(12'(DATA_BASE + 4 * r[15:10]), 5'd0, 3'b010, rd, 7'b0000011);
				end
				11, 12: begin
					prog[i] = storeOp(12'(DATA_BASE + 4 * r[15:10]), src1, 5'd0);
					rd = lastRd;
				end
				13: begin
					prog[i] = branchOp(13'(4 * (target - i)), src2, src1, {2'b00, r[8]});
					rd = lastRd;
				end
				14: prog[i] = jumpOp(21'(4 * (target - i)), rd);
				15: prog[i] = immOp(12'(4 * target), 5'd0, 3'b000, rd, 7'b1100111);
				default: begin
					rd = 5'(i + 1);  // Seed x1 to x15
					prog[i] = immOp(imm, 5'd0, 3'b000, rd, 7'b0010011);
				end
			endcase
			lastRd = rd;
		end
		// Dump x1 to x15, then spin
		for (int k = 1; k <= 15; k++) begin
			prog[BODY_LEN + k - 1] = storeOp(12'(DUMP_BASE + 4 * (k - 1)), 5'(k), 5'd0);
		end
		prog[PROG_LEN - 1] = jumpOp(21'd0, 5'd0);
	endtask

	task automatic loadMemories();
		logic [31:0] inst;
		for (int w = 0; w < MEM_WORDS; w++) begin
			inst = (w < PROG_LEN) ? prog[w] : `NOP_INST;
			imem[w] = {inst[7:0], inst[15:8], inst[23:16], inst[31:24]};
			dmem[w] = {fillByte(4 * w), fillByte(4 * w + 1), fillByte(4 * w + 2),
				fillByte(4 * w + 3)};
		end
		for (int b = 0; b < MEM_WORDS * 4; b++) begin
			modelMem[b] = fillByte(b);
		end
	endtask

	// ==============================
	// ISA reference model
	// ==============================

	function automatic logic [31:0] aluResult(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt) begin
					return $signed(a) >>> b[4:0];
				end
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic void writeReg(input logic [4:0] rd, input logic [31:0] value);
		if (rd != 5'd0) begin
			modelRegs[rd] = value;
		end
	endfunction

	task automatic runModel();
		logic [31:0] pc;
		logic [31:0] next;
		logic [31:0] inst;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] addr;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] immJ;
		int          steps;
		bit          done;
		for (int r = 0; r < 32; r++) begin
			modelRegs[r] = '0;
		end
		expAddr.delete();
		expData.delete();
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < MODEL_LIMIT) begin
			inst = prog[pc[31:2]];
			a = modelRegs[inst[19:15]];
			b = modelRegs[inst[24:20]];
			immI = {{20{inst[31]}}, inst[31:20]};
			immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			next = pc + 32'd4;
			case (inst[6:0])
				7'b0110011: writeReg(inst[11:7], aluResult(inst[14:12], inst[30], a, b));
				7'b0010011: begin
					writeReg(inst[11:7],
						aluResult(inst[14:12], inst[14:12] == 3'd5 && inst[30], a, immI));
				end
				7'b0000011: begin
					addr = a + immI;
					writeReg(inst[11:7], {modelMem[addr + 3], modelMem[addr + 2],
						modelMem[addr + 1], modelMem[addr]});
				end
				7'b0100011: begin
					addr = a + immS;
					modelMem[addr] = b[7:0];  // Little-endian
					modelMem[addr + 1] = b[15:8];
					modelMem[addr + 2] = b[23:16];
					modelMem[addr + 3] = b[31:24];
					expAddr.push_back(addr[31:2]);
					expData.push_back({modelMem[addr], modelMem[addr + 1],
						modelMem[addr + 2], modelMem[addr + 3]});
				end
				7'b1100011: begin
					if ((a == b) != inst[12]) begin
						next = pc + immB;
					end
				end
				7'b1101111: begin
					writeReg(inst[11:7], pc + 32'd4);
					next = pc + immJ;
				end
				7'b1100111: begin
					writeReg(inst[11:7], pc + 32'd4);
					next = (a + immI) & ~32'd1;
				end
				default: begin
					errorCount++;
					$display("Model met an unknown instruction %h in %s", inst, testName);
				end
			endcase
			done = (next == pc);
			pc = next;
			steps++;
		end
		if (!done) begin
			errorCount++;
			$display("Model never reached the end loop of %s", testName);
		end
	endtask

	// ==============================
	// Checks and cycle stepping
	// ==============================

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// A store counts in the cycle where both stalls are low
	task automatic watchStore();
		if (rst_n && dWrite && !dStall && !iStall) begin
			if (storeIdx < expAddr.size()) begin
				checkValue($sformatf("%s store %0d address", testName, storeIdx),
					32'(expAddr[storeIdx]), 32'(dAddr));
				checkValue($sformatf("%s store %0d data", testName, storeIdx),
					expData[storeIdx], dWdata);
			end else begin
				errorCount++;
				$display("%s: store to word %h came after the expected sequence ended",
					testName, dAddr);
			end
			dmem[dAddr[8:0]] = dWdata;
			storeIdx++;
		end
	endtask

	task automatic nextCycle();
		@(negedge clk);
		if (stallsOn && iStallLeft == 0 && nextRand() % 4 == 0) begin
			iStallLeft = 1 + int'(nextRand() % 3);
		end
		if (stallsOn && dStallLeft == 0 && nextRand() % 4 == 0) begin
			dStallLeft = 1 + int'(nextRand() % 3);
		end
		iStall = (iStallLeft > 0);
		dStall = (dStallLeft > 0);
		if (iStallLeft > 0) begin
			iStallLeft--;
		end
		if (dStallLeft > 0) begin
			dStallLeft--;
		end
		watchStore();
	endtask

	task automatic runTest(input string name, input bit withStalls);
		int          cycles;
		logic [31:0] b;
		testName = name;
		loadMemories();
		runModel();
		storeIdx = 0;
		stallsOn = 1'b0;
		iStallLeft = 0;
		dStallLeft = 0;
		iStall = 1'b0;
		dStall = 1'b0;
		rst_n = 1'b0;
		for (int i = 0; i < 5; i++) begin
			nextCycle();
			checkValue($sformatf("%s dRead in reset", name), 32'd0, 32'(dRead));
			checkValue($sformatf("%s dWrite in reset", name), 32'd0, 32'(dWrite));
			checkValue($sformatf("%s iRead in reset", name), 32'd0, 32'(iRead));
		end
		rst_n = 1'b1;
		checkValue($sformatf("%s first fetch address", name), 32'd0, 32'(iAddr));
		stallsOn = withStalls;
		cycles = 0;
		while (storeIdx < expAddr.size() && cycles < RUN_LIMIT) begin
			nextCycle();
			checkValue($sformatf("%s iRead out of reset", name), 32'd1, 32'(iRead));
			cycles++;
		end
		if (storeIdx < expAddr.size()) begin
			errorCount++;
			$display("Timeout: %s made %0d of %0d stores in %0d cycles", name, storeIdx,
				expAddr.size(), RUN_LIMIT);
		end
		// Idle in the end loop, no store may follow
		cycles = 0;
		while (cycles < DRAIN_CYCLES) begin
			nextCycle();
			cycles++;
		end
		for (int k = 0; k < 15; k++) begin
			b = DUMP_BASE + 4 * k;
			checkValue($sformatf("%s dump x%0d", name, k + 1),
				{modelMem[b], modelMem[b + 1], modelMem[b + 2], modelMem[b + 3]},
				dmem[b[10:2]]);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		iStall = 1'b0;
		dStall = 1'b0;
		rngState = 32'd221;
		errorCount = 0;
		checkCount = 0;
		storeIdx = 0;
		stallsOn = 1'b0;
		iStallLeft = 0;
		dStallLeft = 0;
		testName = "startup";
		// Each program runs once clean and once under random stalls
		for (int t = 0; t < NUM_PROGRAMS; t++) begin
			genProgram();
			runTest($sformatf("program%0d", t), 1'b0);
			runTest($sformatf("program%0d_stalled", t), 1'b1);
		end
		// Protocol assertion failures count as errors
		errorCount += riscvCore_i.protocolChecks.failCount;
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* riscvCore.f */
+incdir+include
rtl/riscvPkg.sv
rtl/stageReg.sv
rtl/fetchUnit.sv
rtl/decodeUnit.sv
rtl/regFile.sv
rtl/hazardUnit.sv
rtl/executeUnit.sv
rtl/riscvCore.sv
tests/riscvCore_assertions.sv
tests/riscvCore_tb.sv

/* Bender.yml */
package:
  name: riscvCore

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/riscvPkg.sv
      - rtl/stageReg.sv
      - rtl/fetchUnit.sv
      - rtl/decodeUnit.sv
      - rtl/regFile.sv
      - rtl/hazardUnit.sv
      - rtl/executeUnit.sv
      - rtl/riscvCore.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/riscvCore_assertions.sv
      - tests/riscvCore_tb.sv
